/* hdl/noc_bridge_pkg.sv */
`default_nettype none

package noc_bridge_pkg;

    // basic words on both sides of the bridge
    typedef logic [63:0] noc_data_t;
    typedef logic [63:0] axi_addr_t;

    // network endpoint fields
    typedef logic [13:0] chipid_t;
    typedef logic [7:0]  coord_t;
    typedef logic [3:0]  fbits_t;

    typedef logic [7:0] msg_type_t;
    typedef logic [7:0] msg_len_t;

    localparam msg_type_t msg_store = 8'd15;
    localparam msg_type_t msg_load  = 8'd14;

    // flits that follow the first header
    localparam msg_len_t store_len = 8'd3; // two more headers plus one data flit
    localparam msg_len_t load_len  = 8'd2;

    // kind of an accepted request, as kept in the order queue
    typedef logic req_kind_t;

    localparam req_kind_t req_store = 1'b0;
    localparam req_kind_t req_load  = 1'b1;

    localparam int phys_addr_width = 40;
    localparam logic [2:0] data_size_8b = 3'd4; // full 8-byte access

    // flits 1 and 3, destination and source endpoint
    typedef struct packed {
        chipid_t   chipid;
        coord_t    xpos;
        coord_t    ypos;
        fbits_t    fbits;
        msg_len_t  length;
        msg_type_t msg_type;
        logic [7:0] mshrid;
        logic [5:0] options;
    } route_hdr_t;

    // flit 2
    typedef struct packed {
        logic [7:0]                 rsvd_hi;
        logic [phys_addr_width-1:0] paddr;
        logic [4:0]                 rsvd_mid;
        logic [2:0]                 data_size;
        logic [7:0]                 rsvd_lo;
    } addr_hdr_t;

    // one outgoing word, read as whichever header the flit position calls for
    typedef union packed {
        route_hdr_t route;
        addr_hdr_t  addr;
        noc_data_t  raw;
    } noc_flit_u;

endpackage

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wval,
    input  logic [WIDTH-1:0] wdata,
    input  logic             ren,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wval && !full;   // writes into a full buffer are dropped
    assign do_rd = ren && !empty;
    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign rdata = mem[rd_ptr];     // head is visible right away

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/write_request_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module write_request_queue import noc_bridge_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    input  noc_data_t wdata,
    input  logic      wvalid,
    output logic      awready,
    output logic      wready,
    output logic      wr_accept,
    output axi_addr_t head_addr,
    output noc_data_t head_data,
    output logic      not_empty,
    input  logic      wr_pop
);

    logic addr_full;
    logic addr_empty;
    logic data_full;
    logic data_empty;
    logic room;

    // address and data always go in and out together, so the two buffers stay aligned
    assign room      = !addr_full && !data_full;
    assign wr_accept = awvalid && wvalid && room;
    assign awready   = wr_accept; // a beat is only taken when its partner is present
    assign wready    = wr_accept;
    assign not_empty = !addr_empty && !data_empty;

    sync_fifo #(
        .WIDTH ($bits(axi_addr_t)),
        .DEPTH (QUEUE_DEPTH)
    ) u_addr_fifo (
        .clk   (clk),
        .rst   (rst),
        .wval  (wr_accept),
        .wdata (awaddr),
        .ren   (wr_pop),
        .rdata (head_addr),
        .full  (addr_full),
        .empty (addr_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(noc_data_t)),
        .DEPTH (QUEUE_DEPTH)
    ) u_data_fifo (
        .clk   (clk),
        .rst   (rst),
        .wval  (wr_accept),
        .wdata (wdata),
        .ren   (wr_pop),
        .rdata (head_data),
        .full  (data_full),
        .empty (data_empty)
    );

endmodule

`default_nettype wire

/* hdl/read_request_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module read_request_queue import noc_bridge_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    input  logic      awvalid,
    input  logic      wvalid,
    output logic      arready,
    output logic      rd_accept,
    output axi_addr_t head_addr,
    output logic      not_empty,
    input  logic      rd_pop
);

    logic full;
    logic empty;
    logic write_presented;

    // a complete write in the same cycle goes first, the read waits a cycle
    assign write_presented = awvalid && wvalid;
    assign arready         = !full && !write_presented;
    assign rd_accept       = arvalid && arready;
    assign not_empty       = !empty;

    sync_fifo #(
        .WIDTH ($bits(axi_addr_t)),
        .DEPTH (QUEUE_DEPTH)
    ) u_addr_fifo (
        .clk   (clk),
        .rst   (rst),
        .wval  (rd_accept),
        .wdata (araddr),
        .ren   (rd_pop),
        .rdata (head_addr),
        .full  (full),
        .empty (empty)
    );

endmodule

`default_nettype wire

/* hdl/flit_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module flit_serializer import noc_bridge_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_accept,
    input  logic      rd_accept,
    input  axi_addr_t wr_head_addr,
    input  noc_data_t wr_head_data,
    input  logic      wr_not_empty,
    output logic      wr_pop,
    input  axi_addr_t rd_head_addr,
    input  logic      rd_not_empty,
    output logic      rd_pop,
    input  chipid_t   src_chipid,
    input  coord_t    src_xpos,
    input  coord_t    src_ypos,
    input  fbits_t    src_fbits,
    input  chipid_t   dest_chipid,
    input  coord_t    dest_xpos,
    input  coord_t    dest_ypos,
    input  fbits_t    dest_fbits,
    output logic      noc2_valid_out,
    output noc_data_t noc2_data_out,
    input  logic      noc2_ready_in
);

    // idle sits on a packet boundary and already shows the first routing header
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_header = 2'd1;
    localparam logic [1:0] st_data   = 2'd2;

    localparam logic [1:0] last_hdr = 2'd2; // index of the source header

    logic [1:0] state_q;
    logic [1:0] flit_cnt;
    logic       order_wval;
    req_kind_t  order_wdata;
    req_kind_t  head_kind;
    logic       order_empty;
    logic       is_store;
    logic       req_ready;
    logic       take;
    logic       pkt_done;
    axi_addr_t  head_addr;
    noc_flit_u  flit;

    // one entry per accepted request, both queues together fit
    sync_fifo #(
        .WIDTH ($bits(req_kind_t)),
        .DEPTH (2 * QUEUE_DEPTH)
    ) u_order_fifo (
        .clk   (clk),
        .rst   (rst),
        .wval  (order_wval),
        .wdata (order_wdata),
        .ren   (pkt_done),
        .rdata (head_kind),
        .full  (),
        .empty (order_empty)
    );

    assign order_wval  = wr_accept || rd_accept; // never both in one cycle
    assign order_wdata = wr_accept ? req_store : req_load;

    assign is_store  = (head_kind == req_store);
    assign req_ready = is_store ? wr_not_empty : rd_not_empty;
    assign head_addr = is_store ? wr_head_addr : rd_head_addr;

    assign noc2_valid_out = !order_empty && req_ready;
    assign take           = noc2_valid_out && noc2_ready_in;

    // a load ends on its source header, a store on its data flit
    assign pkt_done = take && ((state_q == st_data) ||
                               (state_q == st_header && flit_cnt == last_hdr && !is_store));
    assign wr_pop   = pkt_done && is_store;
    assign rd_pop   = pkt_done && !is_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= st_idle;
            flit_cnt <= '0;
        end else if (take) begin
            case (state_q)
                st_idle: begin
                    state_q  <= st_header;
                    flit_cnt <= 2'd1;
                end
                st_header: begin
                    if (flit_cnt == last_hdr) begin
                        flit_cnt <= '0;
                        state_q  <= is_store ? st_data : st_idle;
                    end else begin
                        flit_cnt <= flit_cnt + 1'b1;
                    end
                end
                st_data: begin
                    state_q <= st_idle; // next packet may start right away
                end
                default: begin
                    state_q  <= st_idle;
                    flit_cnt <= '0;
                end
            endcase
        end
    end

    always_comb begin
        flit.raw = '0;
        if (state_q == st_data) begin
            flit.raw = wr_head_data;
        end else begin
            case (flit_cnt)
                2'd0: begin
                    flit.route.chipid   = dest_chipid;
                    flit.route.xpos     = dest_xpos;
                    flit.route.ypos     = dest_ypos;
                    flit.route.fbits    = dest_fbits;
                    flit.route.length   = is_store ? store_len : load_len;
                    flit.route.msg_type = is_store ? msg_store : msg_load;
                end
                2'd1: begin
                    flit.addr.paddr     = head_addr[phys_addr_width-1:0];
                    flit.addr.data_size = data_size_8b;
                end
                2'd2: begin
                    // return path for the response
                    flit.route.chipid = src_chipid;
                    flit.route.xpos   = src_xpos;
                    flit.route.ypos   = src_ypos;
                    flit.route.fbits  = src_fbits;
                end
                default: begin
                    flit.raw = '0;
                end
            endcase
        end
    end

    assign noc2_data_out = flit.raw;

endmodule

`default_nettype wire

/* hdl/axilite_noc_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module axilite_noc_bridge import noc_bridge_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    output logic      noc2_valid_out,
    output noc_data_t noc2_data_out,
    input  logic      noc2_ready_in,
    input  chipid_t   src_chipid,
    input  coord_t    src_xpos,
    input  coord_t    src_ypos,
    input  fbits_t    src_fbits,
    input  chipid_t   dest_chipid,
    input  coord_t    dest_xpos,
    input  coord_t    dest_ypos,
    input  fbits_t    dest_fbits,
    input  axi_addr_t m_axi_awaddr,
    input  logic      m_axi_awvalid,
    output logic      m_axi_awready,
    input  noc_data_t m_axi_wdata,
    input  logic [$bits(noc_data_t)/8-1:0] m_axi_wstrb, // every store is a full 8 bytes
    input  logic      m_axi_wvalid,
    output logic      m_axi_wready,
    input  axi_addr_t m_axi_araddr,
    input  logic      m_axi_arvalid,
    output logic      m_axi_arready
);

    logic      wr_accept;
    logic      rd_accept;
    axi_addr_t wr_head_addr;
    noc_data_t wr_head_data;
    logic      wr_not_empty;
    logic      wr_pop;
    axi_addr_t rd_head_addr;
    logic      rd_not_empty;
    logic      rd_pop;

    write_request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_write_request_queue (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (m_axi_awaddr),
        .awvalid   (m_axi_awvalid),
        .wdata     (m_axi_wdata),
        .wvalid    (m_axi_wvalid),
        .awready   (m_axi_awready),
        .wready    (m_axi_wready),
        .wr_accept (wr_accept),
        .head_addr (wr_head_addr),
        .head_data (wr_head_data),
        .not_empty (wr_not_empty),
        .wr_pop    (wr_pop)
    );

    read_request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_read_request_queue (
        .clk       (clk),
        .rst       (rst),
        .araddr    (m_axi_araddr),
        .arvalid   (m_axi_arvalid),
        .awvalid   (m_axi_awvalid),
        .wvalid    (m_axi_wvalid),
        .arready   (m_axi_arready),
        .rd_accept (rd_accept),
        .head_addr (rd_head_addr),
        .not_empty (rd_not_empty),
        .rd_pop    (rd_pop)
    );

    flit_serializer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_flit_serializer (
        .clk            (clk),
        .rst            (rst),
        .wr_accept      (wr_accept),
        .rd_accept      (rd_accept),
        .wr_head_addr   (wr_head_addr),
        .wr_head_data   (wr_head_data),
        .wr_not_empty   (wr_not_empty),
        .wr_pop         (wr_pop),
        .rd_head_addr   (rd_head_addr),
        .rd_not_empty   (rd_not_empty),
        .rd_pop         (rd_pop),
        .src_chipid     (src_chipid),
        .src_xpos       (src_xpos),
        .src_ypos       (src_ypos),
        .src_fbits      (src_fbits),
        .dest_chipid    (dest_chipid),
        .dest_xpos      (dest_xpos),
        .dest_ypos      (dest_ypos),
        .dest_fbits     (dest_fbits),
        .noc2_valid_out (noc2_valid_out),
        .noc2_data_out  (noc2_data_out),
        .noc2_ready_in  (noc2_ready_in)
    );

endmodule

`default_nettype wire

/* testbench/tb_axilite_noc_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axilite_noc_bridge import noc_bridge_pkg::*;;

    localparam int total_requests = 50 + 50 + 60 + 40 + 32;
    localparam int timeout_cycles = 4 * total_requests * 8 + 200;
    localparam int drain_limit    = 2000;

    logic      clk;
    logic      rst;
    logic      noc2_valid_out;
    noc_data_t noc2_data_out;
    logic      noc2_ready_in;
    chipid_t   src_chipid;
    coord_t    src_xpos;
    coord_t    src_ypos;
    fbits_t    src_fbits;
    chipid_t   dest_chipid;
    coord_t    dest_xpos;
    coord_t    dest_ypos;
    fbits_t    dest_fbits;
    axi_addr_t m_axi_awaddr;
    logic      m_axi_awvalid;
    logic      m_axi_awready;
    noc_data_t m_axi_wdata;
    logic [7:0] m_axi_wstrb;
    logic      m_axi_wvalid;
    logic      m_axi_wready;
    axi_addr_t m_axi_araddr;
    logic      m_axi_arvalid;
    logic      m_axi_arready;

    int        seed;
    noc_data_t exp_flits[$];  // expected flits of all outstanding packets in order
    bit        exp_last[$];   // marks the last flit of each packet
    bit        wr_fire;       // seen at the falling edge before the accepting rise
    bit        rd_fire;
    bit        valid_s;
    bit        awready_s;
    bit        arready_s;
    bit        held;
    noc_data_t held_data;
    int        n_wr_acc;
    int        n_rd_acc;
    int        both_seen;
    int        pkts_seen;
    int        flits_checked;
    int        err_cnt;
    int        err_mark;
    int        pkt_mark;
    int        tests_run;
    int        tests_failed;
    int        cycle_cnt;

    axilite_noc_bridge #(.QUEUE_DEPTH(16)) u_axilite_noc_bridge (
        .clk            (clk),
        .rst            (rst),
        .noc2_valid_out (noc2_valid_out),
        .noc2_data_out  (noc2_data_out),
        .noc2_ready_in  (noc2_ready_in),
        .src_chipid     (src_chipid),
        .src_xpos       (src_xpos),
        .src_ypos       (src_ypos),
        .src_fbits      (src_fbits),
        .dest_chipid    (dest_chipid),
        .dest_xpos      (dest_xpos),
        .dest_ypos      (dest_ypos),
        .dest_fbits     (dest_fbits),
        .m_axi_awaddr   (m_axi_awaddr),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_awready  (m_axi_awready),
        .m_axi_wdata    (m_axi_wdata),
        .m_axi_wstrb    (m_axi_wstrb),
        .m_axi_wvalid   (m_axi_wvalid),
        .m_axi_wready   (m_axi_wready),
        .m_axi_araddr   (m_axi_araddr),
        .m_axi_arvalid  (m_axi_arvalid),
        .m_axi_arready  (m_axi_arready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // chip id, x, y, fbits, length, type, then mshr id and options as zero
    function automatic noc_data_t route_header(input logic [13:0] chip, input logic [7:0] x,
                                               input logic [7:0] y, input logic [3:0] f,
                                               input logic [7:0] len, input logic [7:0] kind);
        return {chip, x, y, f, len, kind, 8'h00, 6'h00};
    endfunction

    function automatic noc_data_t address_header(input axi_addr_t addr);
        return {8'h00, addr[39:0], 5'h00, 3'd4, 8'h00};
    endfunction

    function automatic bit chance(input int pct);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return (r % 100) < pct;
    endfunction

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic push_store(input axi_addr_t addr, input noc_data_t data);
        exp_flits.push_back(route_header(dest_chipid, dest_xpos, dest_ypos, dest_fbits,
                                         8'd3, 8'd15));
        exp_flits.push_back(address_header(addr));
        exp_flits.push_back(route_header(src_chipid, src_xpos, src_ypos, src_fbits,
                                         8'd0, 8'd0));
        exp_flits.push_back(data);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b1);
    endtask

    task automatic push_load(input axi_addr_t addr);
        exp_flits.push_back(route_header(dest_chipid, dest_xpos, dest_ypos, dest_fbits,
                                         8'd2, 8'd14));
        exp_flits.push_back(address_header(addr));
        exp_flits.push_back(route_header(src_chipid, src_xpos, src_ypos, src_fbits,
                                         8'd0, 8'd0));
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b0);
        exp_last.push_back(1'b1);
    endtask

    task automatic compare_flit(input noc_data_t got);
        noc_data_t want;
        bit        last;
        assert (exp_flits.size() != 0) else begin
            $display("flit %h at %0t came out with no packet outstanding", got, $time);
            err_cnt++;
        end
        if (exp_flits.size() != 0) begin
            want = exp_flits.pop_front();
            last = exp_last.pop_front();
            flits_checked++;
            assert (got == want) else begin
                $display("mismatch at %0t: flit expected %h got %h", $time, want, got);
                err_cnt++;
            end
            if (last) pkts_seen++;
        end
    endtask

    // monitor on the falling edge where everything has settled
    always @(negedge clk) begin
        wr_fire   = m_axi_awvalid && m_axi_awready && m_axi_wvalid && m_axi_wready;
        rd_fire   = m_axi_arvalid && m_axi_arready;
        valid_s   = noc2_valid_out;
        awready_s = m_axi_awready;
        arready_s = m_axi_arready;
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin
                assert (noc2_valid_out && noc2_data_out == held_data) else begin
                    $display("mismatch at %0t: stalled flit expected %h got %h valid %b",
                             $time, held_data, noc2_data_out, noc2_valid_out);
                    err_cnt++;
                end
            end
            held      = noc2_valid_out && !noc2_ready_in;
            held_data = noc2_data_out;
            if (noc2_valid_out && noc2_ready_in) compare_flit(noc2_data_out);
            // both write channels are taken together
            assert (m_axi_wready == m_axi_awready) else begin
                $display("mismatch at %0t: wready expected %b got %b",
                         $time, m_axi_awready, m_axi_wready);
                err_cnt++;
            end
            if (m_axi_awvalid && m_axi_wvalid && m_axi_arvalid) begin
                both_seen++;
                assert (!m_axi_arready) else begin
                    $display("mismatch at %0t: arready expected 0 got 1 beside a write", $time);
                    err_cnt++;
                end
            end
            if (wr_fire) begin
                n_wr_acc++;
                push_store(m_axi_awaddr, m_axi_wdata);
            end
            if (rd_fire) begin
                n_rd_acc++;
                push_load(m_axi_araddr);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_valid_low();
        assert (!noc2_valid_out) else begin
            $display("mismatch at %0t: noc2_valid_out expected 0 got 1", $time);
            err_cnt++;
        end
    endtask

    task automatic start_test();
        err_mark = err_cnt;
        pkt_mark = pkts_seen;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt != err_mark) tests_failed++;
        $display("%-14s %0d packets, %0d errors", name, pkts_seen - pkt_mark, err_cnt - err_mark);
    endtask

    // random AXI traffic until n_req requests are accepted with each valid held until taken
    task automatic run_traffic(input int n_req, input int p_wr, input int p_rd,
                               input int p_ready);
        int issued;
        int taken;
        issued = 0;
        taken  = 0;
        while (taken < n_req) begin
            @(posedge clk);
            if (wr_fire) taken++;
            if (rd_fire) taken++;
            noc2_ready_in <= chance(p_ready);
            if (!(m_axi_awvalid && !wr_fire)) begin
                if (issued < n_req && chance(p_wr)) begin
                    m_axi_awvalid <= 1'b1;
                    m_axi_wvalid  <= 1'b1;
                    m_axi_awaddr  <= rand_word();
                    m_axi_wdata   <= rand_word();
                    issued++;
                end else begin
                    m_axi_awvalid <= 1'b0;
                    m_axi_wvalid  <= 1'b0;
                end
            end
            if (!(m_axi_arvalid && !rd_fire)) begin
                if (issued < n_req && chance(p_rd)) begin
                    m_axi_arvalid <= 1'b1;
                    m_axi_araddr  <= rand_word();
                    issued++;
                end else begin
                    m_axi_arvalid <= 1'b0;
                end
            end
        end
    endtask

    task automatic drain_packets();
        int waited;
        waited = 0;
        @(posedge clk);
        noc2_ready_in <= 1'b1;
        while (exp_flits.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
        assert (exp_flits.size() == 0 && !valid_s) else begin
            $display("test ended with %0d expected flits never sent, valid still %b",
                     exp_flits.size(), valid_s);
            err_cnt++;
        end
    endtask

    // network stalled so exactly one queue depth of each kind gets in
    task automatic fill_queues();
        int wr_base;
        int rd_base;
        wr_base = n_wr_acc;
        rd_base = n_rd_acc;
        @(posedge clk);
        noc2_ready_in <= 1'b0;
        m_axi_awvalid <= 1'b1;
        m_axi_wvalid  <= 1'b1;
        m_axi_awaddr  <= rand_word();
        m_axi_wdata   <= rand_word();
        repeat (40) begin
            @(posedge clk);
            if (wr_fire) begin
                m_axi_awaddr <= rand_word();
                m_axi_wdata  <= rand_word();
            end
        end
        assert (n_wr_acc - wr_base == 16 && !awready_s) else begin
            $display("mismatch at %0t: accepted writes expected 16 got %0d, awready %b",
                     $time, n_wr_acc - wr_base, awready_s);
            err_cnt++;
        end
        m_axi_awvalid <= 1'b0;
        m_axi_wvalid  <= 1'b0;
        m_axi_arvalid <= 1'b1;
        m_axi_araddr  <= rand_word();
        repeat (40) begin
            @(posedge clk);
            if (rd_fire) m_axi_araddr <= rand_word();
        end
        assert (n_rd_acc - rd_base == 16 && !arready_s) else begin
            $display("mismatch at %0t: accepted reads expected 16 got %0d, arready %b",
                     $time, n_rd_acc - rd_base, arready_s);
            err_cnt++;
        end
        m_axi_arvalid <= 1'b0;
    endtask

    initial begin
        seed          = 74;
        rst           = 1'b1;
        noc2_ready_in = 1'b0;
        m_axi_awaddr  = '0;
        m_axi_awvalid = 1'b0;
        m_axi_wdata   = '0;
        m_axi_wstrb   = 8'hff;
        m_axi_wvalid  = 1'b0;
        m_axi_araddr  = '0;
        m_axi_arvalid = 1'b0;
        // endpoints stay fixed for the whole run
        src_chipid    = 14'($random(seed));
        src_xpos      = 8'($random(seed));
        src_ypos      = 8'($random(seed));
        src_fbits     = 4'($random(seed));
        dest_chipid   = 14'($random(seed));
        dest_xpos     = 8'($random(seed));
        dest_ypos     = 8'($random(seed));
        dest_fbits    = 4'($random(seed));

        start_test();
        repeat (15) begin
            @(negedge clk);
            check_valid_low();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_valid_low();
        end
        finish_test("reset");

        start_test();
        run_traffic(50, 60, 0, 100);
        drain_packets();
        finish_test("stores");

        start_test();
        run_traffic(50, 0, 60, 100);
        drain_packets();
        finish_test("loads");

        start_test();
        both_seen = 0;
        run_traffic(60, 50, 50, 100);
        drain_packets();
        assert (both_seen > 0) else begin
            $display("order test never presented a write and a read in the same cycle");
            err_cnt++;
        end
        finish_test("order");

        start_test();
        run_traffic(40, 40, 40, 30);
        drain_packets();
        finish_test("back-pressure");

        start_test();
        fill_queues();
        drain_packets();
        finish_test("full queues");

        $display("tests %0d, failed %0d, flits checked %0d, errors %0d",
                 tests_run, tests_failed, flits_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/noc_bridge_pkg.sv
hdl/sync_fifo.sv
hdl/write_request_queue.sv
hdl/read_request_queue.sv
hdl/flit_serializer.sv
hdl/axilite_noc_bridge.sv
testbench/tb_axilite_noc_bridge.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axilite_noc_bridge
FILELIST = build.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
